// ==== l0_cache_consts.svh ====
// ----------------------------------------
// sizes of the level-0 instruction cache
// line and word widths must be powers of two
// fetch word must be narrower than a line
// ----------------------------------------
`ifndef L0_CACHE_CONSTS_SVH
`define L0_CACHE_CONSTS_SVH

// fetch port
`define L0_FETCH_AW 32
`define L0_FETCH_DW 32

// cache geometry
`define L0_LINE_WIDTH 128
`define L0_LINE_COUNT 4

// ----------------------------------------
// derived alignments
// ----------------------------------------
// byte offset bits within a line and within a word
`define L0_LINE_ALIGN ($clog2(`L0_LINE_WIDTH / 8))
`define L0_FETCH_ALIGN ($clog2(`L0_FETCH_DW / 8))
// line address bits kept in the tag
`define L0_TAG_WIDTH (`L0_FETCH_AW - `L0_LINE_ALIGN)

`endif

// ==== l0_data_pkg.sv ====
// ----------------------------------------
// datapath types of the level-0 cache
// widths follow the consts header
// ----------------------------------------
`include "l0_cache_consts.svh"

package l0_data_pkg;

  // fetch address or line-aligned request address
  typedef logic [`L0_FETCH_AW-1:0] addr_t;

  // line address with the byte offset stripped
  typedef logic [`L0_TAG_WIDTH-1:0] tag_t;

  // one full cache line as returned by the next level
  typedef logic [`L0_LINE_WIDTH-1:0] line_t;

  // one instruction word on the fetch port
  typedef logic [`L0_FETCH_DW-1:0] word_t;

  // one bit per line, used for hit, evict and write strobes
  typedef logic [`L0_LINE_COUNT-1:0] line_sel_t;

endpackage

// ==== l0_ctrl_pkg.sv ====
// ----------------------------------------
// control types of the level-0 cache
// ----------------------------------------
`include "l0_cache_consts.svh"

package l0_ctrl_pkg;

  // kind of a next-level request, echoed on the response
  typedef enum logic {
    REQ_REFILL,
    REQ_PREFETCH
  } req_kind_e;

  // refill state machine
  typedef enum logic [1:0] {
    MISS_IDLE,
    MISS_REQ,
    MISS_WAIT
  } miss_state_e;

  // round-robin victim pointer
  typedef logic [$clog2(`L0_LINE_COUNT)-1:0] victim_ptr_t;

endpackage

// ==== l0_tag_array.sv ====
// ----------------------------------------
// tag and valid storage, fully associative
// evict writes the tag and clears valid
// flush overrides a validate in the same cycle
// ----------------------------------------
`include "l0_cache_consts.svh"

module l0_tag_array (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  l0_data_pkg::tag_t      fetch_tag_i,
  input  l0_data_pkg::tag_t      pf_tag_i,
  input  l0_data_pkg::line_sel_t evict_i,
  input  l0_data_pkg::tag_t      evict_tag_i,
  input  l0_data_pkg::line_sel_t validate_i,
  input  logic                   flush_i,
  output l0_data_pkg::line_sel_t hit_o,
  output logic                   pf_hit_o
);

  import l0_data_pkg::*;

  tag_t      tag_q [`L0_LINE_COUNT];
  line_sel_t valid_q;
  line_sel_t pf_match;

  // ----------------------------------------
  // compare
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      hit_o[i]    = valid_q[i] & (tag_q[i] == fetch_tag_i);
      pf_match[i] = valid_q[i] & (tag_q[i] == pf_tag_i);
    end
  end

  assign pf_hit_o = |pf_match;

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < `L0_LINE_COUNT; i++) begin
        if (evict_i[i]) begin
          valid_q[i] <= 1'b0;
        end else if (validate_i[i]) begin
          valid_q[i] <= 1'b1;
        end
      end
      // invalidate everything, refills in flight refetch later
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  // tags are only meaningful while the valid bit is set
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      if (evict_i[i]) begin
        tag_q[i] <= evict_tag_i;
      end
    end
  end

endmodule

// ==== l0_data_array.sv ====
// ----------------------------------------
// line data storage and fetch word select
// hit vector is expected one-hot or zero
// ----------------------------------------
`include "l0_cache_consts.svh"

module l0_data_array (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  l0_data_pkg::line_sel_t                       wr_i,
  input  l0_data_pkg::line_t                           wr_line_i,
  input  l0_data_pkg::line_sel_t                       hit_i,
  input  logic [`L0_LINE_ALIGN-`L0_FETCH_ALIGN-1:0]    word_off_i,
  output l0_data_pkg::word_t                           word_o
);

  import l0_data_pkg::*;

  line_t data_q [`L0_LINE_COUNT];
  line_t hit_line;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `L0_LINE_COUNT; i++) begin
        data_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `L0_LINE_COUNT; i++) begin
        if (wr_i[i]) begin
          data_q[i] <= wr_line_i;
        end
      end
    end
  end

  // and-or mux over the hitting line
  always_comb begin
    hit_line = '0;
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      hit_line |= {`L0_LINE_WIDTH{hit_i[i]}} & data_q[i];
    end
  end

  // word within the line, lowest address in the low bits
  assign word_o = hit_line[word_off_i * `L0_FETCH_DW +: `L0_FETCH_DW];

endmodule

// ==== l0_prefetcher.sv ====
// ----------------------------------------
// next-line prefetch address and request
// launch is ignored while a request is held
// ----------------------------------------
`include "l0_cache_consts.svh"

module l0_prefetcher (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  l0_data_pkg::addr_t  fetch_addr_i,
  input  logic                launch_i,
  input  logic                grant_i,
  output l0_data_pkg::tag_t   next_tag_o,
  output logic                req_valid_o,
  output l0_data_pkg::addr_t  req_addr_o
);

  import l0_data_pkg::*;

  tag_t fetch_tag;
  tag_t req_tag_q;
  logic req_valid_q;
  logic accept;

  assign fetch_tag  = fetch_addr_i[`L0_FETCH_AW-1:`L0_LINE_ALIGN];
  // line directly after the one being fetched
  assign next_tag_o = fetch_tag + tag_t'(1);

  assign accept = launch_i & ~req_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (accept) begin
      req_valid_q <= 1'b1;
    end else if (grant_i) begin
      req_valid_q <= 1'b0;
    end
  end

  // address stays put after grant until the next launch
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_tag_q <= next_tag_o;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_addr_o  = {req_tag_q, {`L0_LINE_ALIGN{1'b0}}};

endmodule

// ==== l0_miss_ctrl.sv ====
// ----------------------------------------
// miss handling, victim choice, arbitration
// one refill and one prefetch in flight at most
// a prefetch shown and stalled keeps the bus
// ----------------------------------------
`include "l0_cache_consts.svh"

module l0_miss_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   in_valid_i,
  input  l0_data_pkg::tag_t      fetch_tag_i,
  input  l0_data_pkg::line_sel_t hit_i,
  input  logic                   pf_hit_i,
  input  logic                   prefetch_en_i,
  input  logic                   pf_req_valid_i,
  input  l0_data_pkg::addr_t     pf_req_addr_i,
  input  l0_data_pkg::tag_t      next_tag_i,
  input  logic                   out_req_ready_i,
  input  logic                   out_rsp_valid_i,
  input  l0_ctrl_pkg::req_kind_e out_rsp_kind_i,
  output l0_data_pkg::line_sel_t evict_o,
  output l0_data_pkg::tag_t      evict_tag_o,
  output l0_data_pkg::line_sel_t validate_o,
  output logic                   pf_launch_o,
  output logic                   pf_grant_o,
  output l0_data_pkg::addr_t     out_req_addr_o,
  output l0_ctrl_pkg::req_kind_e out_req_kind_o,
  output logic                   out_req_valid_o
);

  import l0_data_pkg::*;
  import l0_ctrl_pkg::*;

  miss_state_e state_q, state_d;
  victim_ptr_t ptr_q, ptr_d;
  line_sel_t   victim, refill_line_q, pf_line_q;
  tag_t        refill_tag_q, refill_tag;
  logic        hit_any, pf_missed_line, miss, miss_start;
  logic        pf_pending_q, pf_lock_q;
  logic        refill_valid, refill_grant, sel_pf;

  assign hit_any = |hit_i;
  // an outstanding prefetch for this very line turns the miss into a wait
  assign pf_missed_line = pf_pending_q & in_valid_i &
                          (pf_req_addr_i[`L0_FETCH_AW-1:`L0_LINE_ALIGN] == fetch_tag_i);
  assign miss        = in_valid_i & ~hit_any & ~pf_missed_line;
  assign miss_start  = (state_q == MISS_IDLE) & miss;
  assign pf_launch_o = prefetch_en_i & in_valid_i & hit_any & ~pf_hit_i & ~pf_pending_q;

  // ----------------------------------------
  // victim choice
  // ----------------------------------------
  always_comb begin
    victim = line_sel_t'(1) << ptr_q;
    ptr_d  = ptr_q + victim_ptr_t'(1);
    // never throw out the line the port is hitting on
    if (victim == hit_i) begin
      victim = line_sel_t'(1) << (ptr_q + victim_ptr_t'(1));
      ptr_d  = ptr_q + victim_ptr_t'(2);
    end
  end

  assign evict_o     = (miss_start | pf_launch_o) ? victim : '0;
  assign evict_tag_o = miss_start ? fetch_tag_i : next_tag_i;

  // ----------------------------------------
  // arbitration, refill first
  // ----------------------------------------
  assign refill_valid = miss_start | (state_q == MISS_REQ);
  assign refill_tag   = (state_q == MISS_IDLE) ? fetch_tag_i : refill_tag_q;
  assign sel_pf       = pf_req_valid_i & (pf_lock_q | ~refill_valid);
  assign refill_grant = refill_valid & ~sel_pf & out_req_ready_i;
  assign pf_grant_o   = sel_pf & out_req_ready_i;

  assign out_req_valid_o = refill_valid | pf_req_valid_i;
  assign out_req_kind_o  = sel_pf ? REQ_PREFETCH : REQ_REFILL;
  assign out_req_addr_o  = sel_pf ? pf_req_addr_i : {refill_tag, {`L0_LINE_ALIGN{1'b0}}};

  // response kind picks the line to validate
  assign validate_o = !out_rsp_valid_i           ? '0 :
                      (out_rsp_kind_i == REQ_PREFETCH) ? pf_line_q : refill_line_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MISS_IDLE: begin
        if (miss_start) begin
          state_d = refill_grant ? MISS_WAIT : MISS_REQ;
        end
      end
      MISS_REQ: begin
        if (refill_grant) begin
          state_d = MISS_WAIT;
        end
      end
      MISS_WAIT: begin
        if (out_rsp_valid_i && out_rsp_kind_i == REQ_REFILL) begin
          state_d = MISS_IDLE;
        end
      end
      default: state_d = MISS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= MISS_IDLE;
      ptr_q        <= '0;
      pf_pending_q <= 1'b0;
      pf_lock_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      pf_lock_q <= sel_pf & ~out_req_ready_i;
      if (miss_start | pf_launch_o) begin
        ptr_q <= ptr_d;
      end
      if (pf_launch_o) begin
        pf_pending_q <= 1'b1;
      end else if (out_rsp_valid_i && out_rsp_kind_i == REQ_PREFETCH) begin
        pf_pending_q <= 1'b0;
      end
    end
  end

  // lines and tag owned by the requests in flight
  always_ff @(posedge clk_i) begin
    if (miss_start) begin
      refill_line_q <= victim;
      refill_tag_q  <= fetch_tag_i;
    end
    if (pf_launch_o) begin
      pf_line_q <= victim;
    end
  end

endmodule

// ==== l0_cache_top.sv ====
// ----------------------------------------
// level-0 instruction cache, one fetch port
// fetch address must stay stable until ready
// next-level responses are always accepted
// ----------------------------------------
`include "l0_cache_consts.svh"

module l0_cache_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   prefetch_en_i,
  input  l0_data_pkg::addr_t     in_addr_i,
  input  logic                   in_valid_i,
  output l0_data_pkg::word_t     in_data_o,
  output logic                   in_ready_o,
  output l0_data_pkg::addr_t     out_req_addr_o,
  output l0_ctrl_pkg::req_kind_e out_req_kind_o,
  output logic                   out_req_valid_o,
  input  logic                   out_req_ready_i,
  input  l0_data_pkg::line_t     out_rsp_data_i,
  input  l0_ctrl_pkg::req_kind_e out_rsp_kind_i,
  input  logic                   out_rsp_valid_i
);

  import l0_data_pkg::*;

  tag_t      fetch_tag, next_tag, evict_tag;
  line_sel_t hit, evict, validate;
  logic      pf_hit, pf_launch, pf_grant, pf_req_valid;
  addr_t     pf_req_addr;

  assign fetch_tag  = in_addr_i[`L0_FETCH_AW-1:`L0_LINE_ALIGN];
  assign in_ready_o = |hit;

  l0_tag_array l0_tag_array_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_tag_i (fetch_tag),
    .pf_tag_i    (next_tag),
    .evict_i     (evict),
    .evict_tag_i (evict_tag),
    .validate_i  (validate),
    .flush_i     (flush_i),
    .hit_o       (hit),
    .pf_hit_o    (pf_hit)
  );

  l0_data_array l0_data_array_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_i       (validate),
    .wr_line_i  (out_rsp_data_i),
    .hit_i      (hit),
    .word_off_i (in_addr_i[`L0_LINE_ALIGN-1:`L0_FETCH_ALIGN]),
    .word_o     (in_data_o)
  );

  l0_prefetcher l0_prefetcher_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_addr_i (in_addr_i),
    .launch_i     (pf_launch),
    .grant_i      (pf_grant),
    .next_tag_o   (next_tag),
    .req_valid_o  (pf_req_valid),
    .req_addr_o   (pf_req_addr)
  );

  l0_miss_ctrl l0_miss_ctrl_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .in_valid_i      (in_valid_i),
    .fetch_tag_i     (fetch_tag),
    .hit_i           (hit),
    .pf_hit_i        (pf_hit),
    .prefetch_en_i   (prefetch_en_i),
    .pf_req_valid_i  (pf_req_valid),
    .pf_req_addr_i   (pf_req_addr),
    .next_tag_i      (next_tag),
    .out_req_ready_i (out_req_ready_i),
    .out_rsp_valid_i (out_rsp_valid_i),
    .out_rsp_kind_i  (out_rsp_kind_i),
    .evict_o         (evict),
    .evict_tag_o     (evict_tag),
    .validate_o      (validate),
    .pf_launch_o     (pf_launch),
    .pf_grant_o      (pf_grant),
    .out_req_addr_o  (out_req_addr_o),
    .out_req_kind_o  (out_req_kind_o),
    .out_req_valid_o (out_req_valid_o)
  );

endmodule

// ==== tb_clk_gen.sv ====
// ----------------------------------------
// clock and reset for the cache testbench
// period 10, reset low for 3 cycles
// ----------------------------------------
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== tb_l0_cache.sv ====
// ----------------------------------------
// testbench for the level-0 instruction cache
// next level returns word = byte address ^ a5a50000
// responses come back in request order
// ----------------------------------------
`include "l0_cache_consts.svh"

module tb_l0_cache;

  import l0_data_pkg::*;
  import l0_ctrl_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic      clk_i;
  logic      rst_ni;
  logic      flush_i;
  logic      prefetch_en_i;
  addr_t     in_addr_i;
  logic      in_valid_i;
  word_t     in_data_o;
  logic      in_ready_o;
  addr_t     out_req_addr_o;
  req_kind_e out_req_kind_o;
  logic      out_req_valid_o;
  logic      out_req_ready_i;
  line_t     out_rsp_data_i;
  req_kind_e out_rsp_kind_i;
  logic      out_rsp_valid_i;

  // memory model state
  logic      rdy_random;
  int        refill_grants;
  int        prefetch_grants;
  addr_t     last_refill_addr;
  addr_t     last_prefetch_addr;
  addr_t     pend_addr [$];
  req_kind_e pend_kind [$];
  int        pend_due [$];

  word_t     exp_word;
  logic      held_q;
  addr_t     held_addr_q;
  req_kind_e held_kind_q;

  tb_clk_gen tb_clk_gen_inst (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  l0_cache_top l0_cache_top_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .prefetch_en_i   (prefetch_en_i),
    .in_addr_i       (in_addr_i),
    .in_valid_i      (in_valid_i),
    .in_data_o       (in_data_o),
    .in_ready_o      (in_ready_o),
    .out_req_addr_o  (out_req_addr_o),
    .out_req_kind_o  (out_req_kind_o),
    .out_req_valid_o (out_req_valid_o),
    .out_req_ready_i (out_req_ready_i),
    .out_rsp_data_i  (out_rsp_data_i),
    .out_rsp_kind_i  (out_rsp_kind_i),
    .out_rsp_valid_i (out_rsp_valid_i)
  );

  // line as the next level returns it with the lowest address in the low word
  function automatic line_t mem_line(input addr_t line_addr);
    line_t line;
    for (int i = 0; i < `L0_LINE_WIDTH / `L0_FETCH_DW; i++) begin
      line[i*`L0_FETCH_DW +: `L0_FETCH_DW] = (line_addr + addr_t'(4 * i)) ^ 32'hA5A5_0000;
    end
    return line;
  endfunction

  assign exp_word = {in_addr_i[`L0_FETCH_AW-1:`L0_FETCH_ALIGN], {`L0_FETCH_ALIGN{1'b0}}} ^
                    32'hA5A5_0000;

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // ----------------------------------------
  // checks on the ports
  // ----------------------------------------
  // request seen stalled one cycle earlier
  always @(posedge clk_i) begin
    held_q      <= out_req_valid_o & ~out_req_ready_i;
    held_addr_q <= out_req_addr_o;
    held_kind_q <= out_req_kind_o;
  end

  fetch_data_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_valid_i && in_ready_o) |-> (in_data_o == exp_word))
    else begin
      $display("[FAIL] t=%0t in_data_o got %h expected %h", $time,
               $sampled(in_data_o), $sampled(exp_word));
      abort_run();
    end

  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    held_q |-> out_req_valid_o)
    else begin
      $display("request valid dropped at t=%0t before it was accepted", $time);
      abort_run();
    end

  req_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    held_q |-> (out_req_addr_o == held_addr_q))
    else begin
      $display("[FAIL] t=%0t out_req_addr_o got %h expected %h", $time,
               $sampled(out_req_addr_o), $sampled(held_addr_q));
      abort_run();
    end

  req_kind_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    held_q |-> (out_req_kind_o == held_kind_q))
    else begin
      $display("[FAIL] t=%0t out_req_kind_o got %0d expected %0d", $time,
               $sampled(out_req_kind_o), $sampled(held_kind_q));
      abort_run();
    end

  req_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_req_valid_o |-> (out_req_addr_o[`L0_LINE_ALIGN-1:0] == '0))
    else begin
      $display("[FAIL] t=%0t out_req_addr_o got %h expected line-aligned", $time,
               $sampled(out_req_addr_o));
      abort_run();
    end

  // ----------------------------------------
  // next-level memory model
  // ----------------------------------------
  initial begin
    int        cycle_cnt;
    logic      granted;
    addr_t     grant_addr;
    req_kind_e grant_kind;
    out_req_ready_i = 1'b1;
    out_rsp_valid_i = 1'b0;
    out_rsp_data_i  = '0;
    out_rsp_kind_i  = REQ_REFILL;
    refill_grants   = 0;
    prefetch_grants = 0;
    cycle_cnt       = 0;
    void'($urandom(32'h9151));
    forever begin
      // handshake as seen right before the edge
      @(posedge clk_i);
      cycle_cnt++;
      granted    = rst_ni && out_req_valid_o && out_req_ready_i;
      grant_addr = out_req_addr_o;
      grant_kind = out_req_kind_o;
      if (granted && grant_kind == REQ_REFILL) begin
        refill_grants++;
        last_refill_addr = grant_addr;
      end else if (granted) begin
        prefetch_grants++;
        last_prefetch_addr = grant_addr;
      end
      @(negedge clk_i);
      if (granted) begin
        pend_addr.push_back(grant_addr);
        pend_kind.push_back(grant_kind);
        pend_due.push_back(cycle_cnt + int'($urandom % 32'd4) + 1);
      end
      if (pend_due.size() > 0 && pend_due[0] <= cycle_cnt + 1) begin
        out_rsp_valid_i = 1'b1;
        out_rsp_data_i  = mem_line(pend_addr.pop_front());
        out_rsp_kind_i  = pend_kind.pop_front();
        void'(pend_due.pop_front());
      end else begin
        out_rsp_valid_i = 1'b0;
      end
      out_req_ready_i = rdy_random ? (($urandom % 32'd2) == 32'd1) : 1'b1;
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    while (!rst_ni && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!rst_ni) begin
      $display("timeout: reset was never released");
      abort_run();
    end
  endtask

  // starts on a falling edge and returns on one
  task automatic fetch_word(input addr_t addr);
    int cycles;
    in_addr_i  = addr;
    in_valid_i = 1'b1;
    cycles     = 0;
    @(posedge clk_i);
    while (!in_ready_o && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!in_ready_o) begin
      $display("timeout: fetch of address %h never completed", addr);
      abort_run();
    end else begin
      @(negedge clk_i);
      in_valid_i = 1'b0;
    end
  endtask

  function automatic logic mem_busy();
    return out_req_valid_o || out_rsp_valid_i || pend_addr.size() > 0;
  endfunction

  task automatic wait_mem_idle();
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    while (mem_busy() && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (mem_busy()) begin
      $display("timeout: next-level traffic did not drain");
      abort_run();
    end else begin
      @(negedge clk_i);
    end
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  task automatic run_core_behaviors(input addr_t base);
    int refills;
    int prefetches;
    // cold miss, then the other words of the line hit
    refills = refill_grants;
    fetch_word(base);
    check_value("refill requests", refill_grants, refills + 1);
    check_value("out_req_addr_o (refill)", last_refill_addr, base);
    for (int w = 1; w < 4; w++) begin
      fetch_word(base + addr_t'(4 * w));
    end
    check_value("refill requests", refill_grants, refills + 1);
    // next-line prefetch launched by a hit
    prefetches    = prefetch_grants;
    prefetch_en_i = 1'b1;
    fetch_word(base);
    prefetch_en_i = 1'b0;
    wait_mem_idle();
    check_value("prefetch requests", prefetch_grants, prefetches + 1);
    check_value("out_req_addr_o (prefetch)", last_prefetch_addr, base + 32'h10);
    fetch_word(base + 32'h14);
    check_value("refill requests", refill_grants, refills + 1);
    // five new lines through four entries push out the first
    for (int k = 0; k < 5; k++) begin
      fetch_word(base + 32'h100 + addr_t'(16 * k));
      check_value("refill requests", refill_grants, refills + 2 + k);
    end
    fetch_word(base + 32'h100);
    check_value("refill requests", refill_grants, refills + 7);
    check_value("out_req_addr_o (refill)", last_refill_addr, base + 32'h100);
    // prefetch queued behind a refill, then a fetch of the prefetched line
    prefetches    = prefetch_grants;
    prefetch_en_i = 1'b1;
    fetch_word(base + 32'h140);
    prefetch_en_i = 1'b0;
    fetch_word(base + 32'h200);
    fetch_word(base + 32'h150);
    wait_mem_idle();
    check_value("refill requests", refill_grants, refills + 8);
    check_value("prefetch requests", prefetch_grants, prefetches + 1);
    check_value("out_req_addr_o (prefetch)", last_prefetch_addr, base + 32'h150);
  endtask

  initial begin
    int refills;
    in_addr_i     = '0;
    in_valid_i    = 1'b0;
    flush_i       = 1'b0;
    prefetch_en_i = 1'b0;
    rdy_random    = 1'b0;
    wait_reset_release();
    check_value("in_ready_o", 32'(in_ready_o), 32'd0);
    check_value("out_req_valid_o", 32'(out_req_valid_o), 32'd0);
    @(negedge clk_i);
    run_core_behaviors(32'h0000_0100);

    // flush drops a line that was present
    pulse_flush();
    refills = refill_grants;
    fetch_word(32'h0000_0240);
    check_value("refill requests", refill_grants, refills + 1);
    check_value("out_req_addr_o (refill)", last_refill_addr, 32'h0000_0240);
    wait_mem_idle();

    // random back-pressure on the request port
    @(posedge clk_i);
    rdy_random = 1'b1;
    @(negedge clk_i);
    pulse_flush();
    run_core_behaviors(32'h0000_4000);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
l0_data_pkg.sv
l0_ctrl_pkg.sv
l0_tag_array.sv
l0_data_array.sv
l0_prefetcher.sv
l0_miss_ctrl.sv
l0_cache_top.sv
tb_clk_gen.sv
tb_l0_cache.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, exit status follows the result
verilator --binary --timing --assert -f compile.f --top-module tb_l0_cache -o tb_l0_cache \
  && ./obj_dir/tb_l0_cache \
  || exit 1
